/* rtl/l2_consts.svh */
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// L2 cache geometry
////////////////////////////////////////////////////////////////////////////

// eight-way set associative
`define L2_WAYS 8

// way index, log2 of L2_WAYS
`define L2_WAY_BITS 3

// instruction refills only go to ways 0..3
`define L2_IWAY_BITS 2

`endif

/* rtl/l2_pkg.sv */
`default_nettype none

`include "l2_consts.svh"

package l2_pkg;

    // main controller states
    typedef enum logic [3:0] {
        idle           = 4'd0,
        lookup         = 4'd1,
        suc_w          = 4'd2,  // uncached write to memory
        suc_w1         = 4'd3,
        check_dirty    = 4'd4,
        check_dirty1   = 4'd5,
        writeback      = 4'd6,
        replace1       = 4'd7,  // refill address phase
        replace2       = 4'd8,  // refill data phase
        replace_write1 = 4'd9,
        replace_write  = 4'd10
    } l2_state_e;

    // request source, as held in the request buffer
    typedef enum logic [1:0] {
        src_none   = 2'd0,
        src_iread  = 2'd1,
        src_dread  = 2'd2,
        src_dwrite = 2'd3
    } req_src_e;

    typedef logic [`L2_WAY_BITS-1:0]  way_idx_t;
    typedef logic [`L2_IWAY_BITS-1:0] iway_idx_t;
    typedef logic [`L2_WAYS-1:0]      way_vec_t;

endpackage

`default_nettype wire

/* rtl/l2_way_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_consts.svh"

module l2_way_tracker (
    input  wire                 clk,
    input  l2_pkg::way_vec_t    hit_i,
    input  wire                 capture_i,
    input  l2_pkg::way_idx_t    victim_d_i,
    input  l2_pkg::iway_idx_t   victim_i_i,
    output l2_pkg::way_idx_t    hit_way_o,
    output logic                hit_any_o,
    output l2_pkg::way_idx_t    victim_d_o,
    output l2_pkg::iway_idx_t   victim_i_o
);

    l2_pkg::way_idx_t  victim_d_q;
    l2_pkg::iway_idx_t victim_i_q;

    ////////////////////////////////////////////////////////////////////////////
    // hit encode
    ////////////////////////////////////////////////////////////////////////////

    // lowest set way wins
    always_comb begin
        hit_way_o = '0;
        for (int i = `L2_WAYS - 1; i >= 0; i--) begin
            if (hit_i[i]) begin
                hit_way_o = l2_pkg::way_idx_t'(i);
            end
        end
    end

    assign hit_any_o = |hit_i;

    ////////////////////////////////////////////////////////////////////////////
    // victim hold
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (capture_i) begin
            victim_d_q <= victim_d_i;
            victim_i_q <= victim_i_i;
        end
    end

    // forward during capture so check_dirty sees the fresh choice
    assign victim_d_o = capture_i ? victim_d_i : victim_d_q;
    assign victim_i_o = capture_i ? victim_i_i : victim_i_q;

endmodule

`default_nettype wire

/* rtl/l2_state_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_state_seq (
    input  wire                 clk,
    input  wire                 rstn,
    input  l2_pkg::req_src_e    req_from_i,
    input  l2_pkg::req_src_e    rbuf_from_i,
    input  wire                 rbuf_suc_i,
    input  wire                 icache_flush_i,
    input  wire                 hit_any_i,
    input  wire                 dirty_i,
    input  wire                 mem_addrok_w_i,
    input  wire                 mem_addrok_r_i,
    input  wire                 mem_dataok_i,
    output l2_pkg::l2_state_e   state_o
);

    l2_pkg::l2_state_e state_q;
    l2_pkg::l2_state_e state_d;
    logic              flush_q;
    logic              i_cancel;

    ////////////////////////////////////////////////////////////////////////////
    // state and flush registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= l2_pkg::idle;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            flush_q <= icache_flush_i;  // flush takes effect a cycle late
        end
    end

    assign i_cancel = flush_q && (rbuf_from_i == l2_pkg::src_iread);

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            l2_pkg::idle: begin
                if (req_from_i != l2_pkg::src_none) begin
                    state_d = l2_pkg::lookup;
                end
            end
            l2_pkg::lookup: begin
                if (i_cancel) begin
                    state_d = l2_pkg::idle;
                end else if (rbuf_suc_i) begin
                    // uncached: write goes straight out, read refills
                    if (rbuf_from_i == l2_pkg::src_dwrite) begin
                        state_d = l2_pkg::suc_w;
                    end else begin
                        state_d = l2_pkg::replace1;
                    end
                end else if (!hit_any_i) begin
                    state_d = l2_pkg::check_dirty;
                end else begin
                    state_d = l2_pkg::idle;
                end
            end
            l2_pkg::suc_w: begin
                if (mem_addrok_w_i) begin
                    state_d = l2_pkg::suc_w1;
                end
            end
            l2_pkg::suc_w1: begin
                state_d = l2_pkg::idle;
            end
            l2_pkg::check_dirty: begin
                state_d = l2_pkg::check_dirty1;  // dirty table read latency
            end
            l2_pkg::check_dirty1: begin
                state_d = dirty_i ? l2_pkg::writeback : l2_pkg::replace1;
            end
            l2_pkg::writeback: begin
                if (mem_addrok_w_i) begin
                    state_d = l2_pkg::replace1;
                end
            end
            l2_pkg::replace1: begin
                if (mem_addrok_r_i) begin
                    state_d = l2_pkg::replace2;
                end
            end
            l2_pkg::replace2: begin
                if (mem_dataok_i) begin
                    // cached write miss still has the word to merge
                    if (rbuf_from_i == l2_pkg::src_dwrite && !rbuf_suc_i) begin
                        state_d = l2_pkg::replace_write1;
                    end else begin
                        state_d = l2_pkg::idle;
                    end
                end
            end
            l2_pkg::replace_write1: begin
                state_d = l2_pkg::replace_write;
            end
            l2_pkg::replace_write: begin
                state_d = l2_pkg::idle;
            end
            default: begin
                state_d = l2_pkg::idle;
            end
        endcase
    end

    assign state_o = state_q;

endmodule

`default_nettype wire

/* rtl/l2_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cmd_decode (
    input  wire                 clk,
    input  wire                 rstn,
    input  l2_pkg::l2_state_e   state_i,
    input  l2_pkg::req_src_e    rbuf_from_i,
    input  wire                 rbuf_suc_i,
    input  wire                 dcache_req_i,
    input  wire                 dcache_wr_i,
    input  wire                 dsuc_i,
    input  wire                 icache_req_i,
    input  wire                 icache_flush_i,
    input  l2_pkg::way_vec_t    hit_i,
    input  l2_pkg::way_idx_t    hit_way_i,
    input  wire                 hit_any_i,
    input  wire                 dirty_i,
    input  l2_pkg::way_idx_t    victim_d_i,
    input  l2_pkg::iway_idx_t   victim_i_i,
    input  wire                 mem_addrok_w_i,
    input  wire                 mem_dataok_i,
    output logic                capture_o,
    output logic                rbuf_we_o,
    output logic                icache_addrok_o,
    output logic                icache_dataok_o,
    output logic                dcache_addrok_o,
    output logic                dcache_dataok_o,
    output logic                mem_req_w_o,
    output logic                mem_req_r_o,
    output logic                mem_rdy_o,
    output l2_pkg::way_vec_t    use_o,
    output l2_pkg::way_vec_t    data_we_o,
    output logic                data_replace_o,
    output logic                data_writeback_o,
    output l2_pkg::way_idx_t    tagv_way_o,
    output l2_pkg::way_idx_t    dirty_way_o,
    output logic                dirty_set1_o,
    output logic                dirty_set0_o,
    output l2_pkg::way_idx_t    choose_way_o,
    output logic                choose_return_o
);

    logic             flush_q;
    logic             is_ireq;
    logic             lookup_ok;
    l2_pkg::way_idx_t vict_way;
    l2_pkg::way_vec_t vict_vec;
    l2_pkg::way_vec_t hit_low;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= icache_flush_i;
        end
    end

    assign is_ireq   = (rbuf_from_i == l2_pkg::src_iread);
    assign lookup_ok = !(is_ireq && flush_q) && !rbuf_suc_i && hit_any_i;

    // icache victims are zero extended into the low ways
    assign vict_way = is_ireq ? l2_pkg::way_idx_t'(victim_i_i) : victim_d_i;
    assign vict_vec = l2_pkg::way_vec_t'(1) << vict_way;
    assign hit_low  = hit_i & (~hit_i + 1'b1);  // isolate lowest hit

    ////////////////////////////////////////////////////////////////////////////
    // strobe decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        capture_o        = 1'b0;
        rbuf_we_o        = 1'b0;
        icache_addrok_o  = 1'b0;
        icache_dataok_o  = 1'b0;
        dcache_addrok_o  = 1'b0;
        dcache_dataok_o  = 1'b0;
        mem_req_w_o      = 1'b0;
        mem_req_r_o      = 1'b0;
        mem_rdy_o        = 1'b0;
        use_o            = '0;
        data_we_o        = '0;
        data_replace_o   = 1'b0;
        data_writeback_o = 1'b0;
        tagv_way_o       = '0;
        dirty_way_o      = '0;
        dirty_set1_o     = 1'b0;
        dirty_set0_o     = 1'b0;
        choose_way_o     = '0;
        choose_return_o  = 1'b0;
        case (state_i)
            l2_pkg::idle: begin
                rbuf_we_o = 1'b1;
                if (dcache_req_i) begin
                    // uncached write gets its addrok after memory accepts
                    dcache_addrok_o = !(dcache_wr_i && dsuc_i);
                end else if (icache_req_i) begin
                    icache_addrok_o = 1'b1;
                end
            end
            l2_pkg::lookup: begin
                if (lookup_ok) begin
                    use_o = hit_low;
                    if (rbuf_from_i == l2_pkg::src_dwrite) begin
                        data_we_o    = hit_low;
                        dirty_way_o  = hit_way_i;
                        dirty_set1_o = 1'b1;
                    end else begin
                        choose_way_o    = hit_way_i;
                        icache_dataok_o = is_ireq;
                        dcache_dataok_o = !is_ireq;
                    end
                end
            end
            l2_pkg::suc_w: mem_req_w_o = 1'b1;
            l2_pkg::suc_w1: dcache_addrok_o = 1'b1;
            l2_pkg::check_dirty: begin
                capture_o   = 1'b1;
                dirty_way_o = vict_way;
            end
            l2_pkg::check_dirty1: data_writeback_o = dirty_i;
            l2_pkg::writeback: begin
                mem_req_w_o      = 1'b1;
                data_writeback_o = !mem_addrok_w_i;  // keep tag read until accepted
                choose_way_o     = vict_way;
                tagv_way_o       = vict_way;
            end
            l2_pkg::replace1: mem_req_r_o = 1'b1;
            l2_pkg::replace2: begin
                mem_rdy_o = 1'b1;
                if (mem_dataok_i) begin
                    choose_return_o = 1'b1;
                    icache_dataok_o = is_ireq;
                    dcache_dataok_o = (rbuf_from_i == l2_pkg::src_dread);
                    if (!rbuf_suc_i) begin
                        data_replace_o = 1'b1;
                        data_we_o      = vict_vec;
                        dirty_way_o    = vict_way;
                        if (rbuf_from_i == l2_pkg::src_dwrite) begin
                            dirty_set1_o = 1'b1;  // use waits for the word write
                        end else begin
                            use_o        = vict_vec;
                            dirty_set0_o = 1'b1;
                        end
                    end
                end
            end
            l2_pkg::replace_write: begin
                data_we_o = vict_vec;
                use_o     = vict_vec;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/l2_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_top (
    input  wire                 clk,
    input  wire                 rstn,
    input  l2_pkg::req_src_e    req_from_i,
    input  l2_pkg::req_src_e    rbuf_from_i,
    input  wire                 rbuf_suc_i,
    input  wire                 dcache_req_i,
    input  wire                 dcache_wr_i,
    input  wire                 dsuc_i,
    input  wire                 icache_req_i,
    input  wire                 icache_flush_i,
    input  l2_pkg::way_vec_t    hit_i,
    input  wire                 dirty_i,
    input  l2_pkg::way_idx_t    victim_d_i,
    input  l2_pkg::iway_idx_t   victim_i_i,
    input  wire                 mem_addrok_w_i,
    input  wire                 mem_addrok_r_i,
    input  wire                 mem_dataok_i,
    output wire                 rbuf_we_o,
    output wire                 icache_addrok_o,
    output wire                 icache_dataok_o,
    output wire                 dcache_addrok_o,
    output wire                 dcache_dataok_o,
    output wire                 mem_req_w_o,
    output wire                 mem_req_r_o,
    output wire                 mem_rdy_o,
    output l2_pkg::way_vec_t    use_o,
    output l2_pkg::way_vec_t    data_we_o,
    output wire                 data_replace_o,
    output wire                 data_writeback_o,
    output l2_pkg::way_idx_t    tagv_way_o,
    output l2_pkg::way_idx_t    dirty_way_o,
    output wire                 dirty_set1_o,
    output wire                 dirty_set0_o,
    output l2_pkg::way_idx_t    choose_way_o,
    output wire                 choose_return_o
);

    l2_pkg::l2_state_e state;
    wire               capture;
    l2_pkg::way_idx_t  hit_way;
    wire               hit_any;
    l2_pkg::way_idx_t  victim_d;
    l2_pkg::iway_idx_t victim_i;

    l2_state_seq u_seq (
        .clk            (clk),
        .rstn           (rstn),
        .req_from_i     (req_from_i),
        .rbuf_from_i    (rbuf_from_i),
        .rbuf_suc_i     (rbuf_suc_i),
        .icache_flush_i (icache_flush_i),
        .hit_any_i      (hit_any),
        .dirty_i        (dirty_i),
        .mem_addrok_w_i (mem_addrok_w_i),
        .mem_addrok_r_i (mem_addrok_r_i),
        .mem_dataok_i   (mem_dataok_i),
        .state_o        (state)
    );

    l2_way_tracker u_ways (
        .clk        (clk),
        .hit_i      (hit_i),
        .capture_i  (capture),
        .victim_d_i (victim_d_i),
        .victim_i_i (victim_i_i),
        .hit_way_o  (hit_way),
        .hit_any_o  (hit_any),
        .victim_d_o (victim_d),
        .victim_i_o (victim_i)
    );

    l2_cmd_decode u_dec (
        .clk (clk), .rstn (rstn), .state_i (state),
        .rbuf_from_i (rbuf_from_i), .rbuf_suc_i (rbuf_suc_i),
        .dcache_req_i (dcache_req_i), .dcache_wr_i (dcache_wr_i), .dsuc_i (dsuc_i),
        .icache_req_i (icache_req_i), .icache_flush_i (icache_flush_i),
        .hit_i (hit_i), .hit_way_i (hit_way), .hit_any_i (hit_any), .dirty_i (dirty_i),
        .victim_d_i (victim_d), .victim_i_i (victim_i),
        .mem_addrok_w_i (mem_addrok_w_i), .mem_dataok_i (mem_dataok_i),
        .capture_o (capture), .rbuf_we_o (rbuf_we_o),
        .icache_addrok_o (icache_addrok_o), .icache_dataok_o (icache_dataok_o),
        .dcache_addrok_o (dcache_addrok_o), .dcache_dataok_o (dcache_dataok_o),
        .mem_req_w_o (mem_req_w_o), .mem_req_r_o (mem_req_r_o), .mem_rdy_o (mem_rdy_o),
        .use_o (use_o), .data_we_o (data_we_o),
        .data_replace_o (data_replace_o), .data_writeback_o (data_writeback_o),
        .tagv_way_o (tagv_way_o), .dirty_way_o (dirty_way_o),
        .dirty_set1_o (dirty_set1_o), .dirty_set0_o (dirty_set0_o),
        .choose_way_o (choose_way_o), .choose_return_o (choose_return_o)
    );

endmodule

`default_nettype wire

/* tests/l2_ctrl_props.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_props (
    input wire                 clk,
    input wire                 rstn,
    input l2_pkg::l2_state_e   state_i,
    input wire                 mem_req_w_i,
    input wire                 mem_req_r_i,
    input wire                 mem_rdy_i,
    input wire                 icache_dataok_i,
    input wire                 dcache_dataok_i
);

    int assert_fails = 0;

    // one memory direction at a time
    assert property (@(posedge clk) disable iff (!rstn) !(mem_req_w_i && mem_req_r_i))
        else begin
            $error("memory read and write requested together");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (!rstn)
        mem_rdy_i |-> (mem_req_r_i || state_i == l2_pkg::replace2))
        else begin
            $error("mem_rdy outside the refill data phase");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (!rstn)
        (state_i == l2_pkg::idle) |-> !(icache_dataok_i || dcache_dataok_i))
        else begin
            $error("dataok strobe while idle");
            assert_fails++;
        end

endmodule

bind l2_ctrl_top l2_ctrl_props u_props (
    .clk (clk), .rstn (rstn), .state_i (state),
    .mem_req_w_i (mem_req_w_o), .mem_req_r_i (mem_req_r_o), .mem_rdy_i (mem_rdy_o),
    .icache_dataok_i (icache_dataok_o), .dcache_dataok_i (dcache_dataok_o)
);

`default_nettype wire

/* tests/l2_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_tb;

    logic clk, rstn, rbuf_suc_i, dcache_req_i, dcache_wr_i, dsuc_i, icache_req_i;
    logic icache_flush_i, dirty_i, mem_addrok_w_i, mem_addrok_r_i, mem_dataok_i;
    l2_pkg::req_src_e req_from_i, rbuf_from_i;
    l2_pkg::way_vec_t hit_i, use_o, data_we_o;
    l2_pkg::way_idx_t victim_d_i, tagv_way_o, dirty_way_o, choose_way_o;
    l2_pkg::iway_idx_t victim_i_i;
    wire rbuf_we_o, icache_addrok_o, icache_dataok_o, dcache_addrok_o, dcache_dataok_o;
    wire mem_req_w_o, mem_req_r_o, mem_rdy_o, data_replace_o, data_writeback_o;
    wire dirty_set1_o, dirty_set0_o, choose_return_o;
    int  err_cnt = 0;
    int  fail_cnt = 0;
    int  txn_no = 0;
    bit  abort = 0;

    l2_ctrl_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_way(input string name, input l2_pkg::way_idx_t exp,
                             input l2_pkg::way_idx_t act);
        if (exp !== act) begin
            err_cnt++;
            $display("CHECK FAILED txn %0d %s: expected %0d, actual %0d", txn_no, name, exp, act);
        end
    endtask

    task automatic check_vec(input string name, input l2_pkg::way_vec_t exp,
                             input l2_pkg::way_vec_t act);
        if (exp !== act) begin
            err_cnt++;
            $display("CHECK FAILED txn %0d %s: expected %b, actual %b", txn_no, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            err_cnt++;
            $display("CHECK FAILED txn %0d %s: expected %b, actual %b", txn_no, name, exp, act);
        end
    endtask

    // a strobe expected at most once
    task automatic check_pulses(input string name, input logic exp, input int n);
        check_bit(name, exp, n != 0);
        check_bit({name, " at most once"}, 1'b1, n <= 1);
    endtask

    function automatic l2_pkg::way_vec_t onehot_of(input l2_pkg::way_idx_t w);
        onehot_of = '0;
        onehot_of[w] = 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // memory responder, random pulse delay
    ////////////////////////////////////////////////////////////////////////////

    initial begin : mem_responder
        logic [2:0] kind;
        int unsigned dly;
        void'($urandom(3));
        forever begin
            @(negedge clk);
            if (rstn && (mem_req_w_o || mem_req_r_o || mem_rdy_o)) begin
                kind = {mem_rdy_o, mem_req_r_o, mem_req_w_o};
                dly  = $urandom_range(5, 0);
                repeat (dly) @(posedge clk);  // request holds meanwhile
                @(posedge clk);
                mem_addrok_w_i <= kind[0];
                mem_addrok_r_i <= kind[1];
                mem_dataok_i   <= kind[2];
                @(posedge clk);
                mem_addrok_w_i <= 1'b0;
                mem_addrok_r_i <= 1'b0;
                mem_dataok_i   <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // one transaction
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_txn(input l2_pkg::req_src_e src, input logic suc,
                           input l2_pkg::way_vec_t hit_v, input logic dirty,
                           input l2_pkg::way_idx_t vd, input l2_pkg::iway_idx_t vi,
                           input l2_pkg::way_idx_t exp_way, input logic [2:0] flags);
        int cyc = 0;
        int first_dok = 0;
        int n_idok = 0, n_ddok = 0, n_set1 = 0, n_set0 = 0, n_ret = 0, n_rw = 0, n_daddr = 0;
        int n_rep = 0;
        logic seen_w = 1'b0, seen_r = 1'b0, any_we = 1'b0, done = 1'b0;
        logic seen_wb = 1'b0;
        logic is_i, is_dw, hit, exp_dok, exp_set1, exp_set0, exp_ret, exp_rw, exp_daddr;
        logic cancel, miss, exp_wb;
        l2_pkg::way_vec_t exp_vec;
        is_i    = (src == l2_pkg::src_iread);
        is_dw   = (src == l2_pkg::src_dwrite);
        hit     = (hit_v != '0);
        cancel  = flags[0] && is_i;  // flushed icache lookups do nothing
        miss    = !cancel && !suc && !hit;
        exp_vec = onehot_of(exp_way);
        {exp_dok, exp_set1, exp_set0, exp_ret, exp_rw, exp_daddr} = '0;
        exp_wb = 1'b0;
        if (!cancel) begin
            if (suc && is_dw) begin
                exp_daddr = 1'b1;
            end else if (suc) begin
                exp_ret = 1'b1;
                exp_dok = 1'b1;
            end else if (hit) begin
                exp_set1 = is_dw;
                exp_dok  = !is_dw;
            end else begin
                // refill clears dirty, a write miss sets it and merges the word
                exp_ret  = 1'b1;
                exp_set1 = is_dw;
                exp_rw   = is_dw;
                exp_set0 = !is_dw;
                exp_dok  = !is_dw;
                exp_wb   = dirty;
            end
        end
        @(posedge clk);
        req_from_i     <= src;
        rbuf_from_i    <= src;
        rbuf_suc_i     <= suc;
        dcache_req_i   <= !is_i;
        dcache_wr_i    <= is_dw;
        dsuc_i         <= suc && !is_i;
        icache_req_i   <= is_i;
        icache_flush_i <= flags[0];
        hit_i          <= hit_v;
        dirty_i        <= dirty;
        victim_d_i     <= vd;
        victim_i_i     <= vi;
        @(negedge clk);
        check_bit("idle dcache addrok", !is_i && !(is_dw && suc), dcache_addrok_o);
        check_bit("idle icache addrok", is_i, icache_addrok_o);
        @(posedge clk);
        req_from_i     <= l2_pkg::src_none;  // taken on this edge
        icache_flush_i <= 1'b0;
        while (!done && cyc < 80) begin
            @(negedge clk);
            cyc++;
            done = rbuf_we_o;
            if (!done) begin
                seen_r = seen_r | mem_req_r_o;
                seen_wb = seen_wb | data_writeback_o;
                any_we = any_we | (data_we_o != '0);
                n_daddr += dcache_addrok_o;
                n_idok += icache_dataok_o;
                n_ddok += dcache_dataok_o;
                n_rep += data_replace_o;
                if ((icache_dataok_o || dcache_dataok_o) && first_dok == 0) first_dok = cyc;
                if (mem_req_w_o) begin
                    seen_w = 1'b1;
                    if (!suc) begin
                        check_way("writeback tagv way", exp_way, tagv_way_o);
                        check_way("writeback choose way", exp_way, choose_way_o);
                    end
                end
                if (choose_return_o) begin
                    n_ret++;
                    check_vec("refill data_we", suc ? '0 : exp_vec, data_we_o);
                    check_bit("refill dataok", !is_dw, icache_dataok_o || dcache_dataok_o);
                end else if (icache_dataok_o || dcache_dataok_o) begin
                    check_way("hit choose way", exp_way, choose_way_o);
                    check_vec("hit use", exp_vec, use_o);
                end
                if (dirty_set1_o || dirty_set0_o) begin
                    n_set1 += dirty_set1_o;
                    n_set0 += dirty_set0_o;
                    check_way("dirty way", exp_way, dirty_way_o);
                    check_vec("data_we with dirty update", exp_vec, data_we_o);
                end else if (data_we_o != '0) begin
                    n_rw++;
                    check_vec("replace_write data_we", exp_vec, data_we_o);
                    check_vec("replace_write use", exp_vec, use_o);
                end
                if (miss && cyc == 2) begin
                    // check_dirty, the victim must be held past this cycle
                    check_way("dirty lookup way", exp_way, dirty_way_o);
                    @(posedge clk);
                    victim_d_i <= ~vd;
                    victim_i_i <= ~vi;
                end
            end
        end
        if (!done) begin
            fail_cnt++;
            abort = 1'b1;
            $display("txn %0d: controller did not return to idle within 80 cycles", txn_no);
        end else begin
            check_bit("memory write request", flags[1], seen_w);
            check_bit("memory read request", flags[2], seen_r);
            check_pulses("icache dataok", exp_dok && is_i, n_idok);
            check_pulses("dcache dataok", exp_dok && !is_i, n_ddok);
            if (exp_dok && hit && !suc) begin
                check_bit("dataok in first lookup cycle", 1'b1, first_dok == 1);
            end
            check_pulses("choose_return", exp_ret, n_ret);
            check_pulses("dirty_set1", exp_set1, n_set1);
            check_pulses("dirty_set0", exp_set0, n_set0);
            check_pulses("replace_write", exp_rw, n_rw);
            check_pulses("dcache addrok after memory", exp_daddr, n_daddr);
            check_pulses("data_replace", miss, n_rep);
            check_bit("writeback array read", exp_wb, seen_wb);
            check_bit("array write", !suc && (exp_set1 || exp_set0), any_we);
        end
        @(posedge clk);
        rbuf_from_i  <= l2_pkg::src_none;
        rbuf_suc_i   <= 1'b0;
        dcache_req_i <= 1'b0;
        dcache_wr_i  <= 1'b0;
        dsuc_i       <= 1'b0;
        icache_req_i <= 1'b0;
        hit_i        <= '0;
        dirty_i      <= 1'b0;
    endtask

    initial begin : main
        int fd;
        int rc;
        int assert_cnt;
        string line;
        logic [31:0] f_src, f_suc, f_hit, f_dirty, f_vd, f_vi, f_way, f_flags;
        {rstn, rbuf_suc_i, dcache_req_i, dcache_wr_i, dsuc_i, icache_req_i} = '0;
        {icache_flush_i, dirty_i, mem_addrok_w_i, mem_addrok_r_i, mem_dataok_i} = '0;
        req_from_i  = l2_pkg::src_none;
        rbuf_from_i = l2_pkg::src_none;
        {hit_i, victim_d_i, victim_i_i} = '0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_bit("reset rbuf_we", 1'b1, rbuf_we_o);
        check_bit("reset mem_req_w", 1'b0, mem_req_w_o);
        fd = $fopen("tests/l2_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            fail_cnt++;
            $display("cannot open tests/l2_ctrl_vectors.txt");
        end else begin
            while (!abort && !$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line[0] != "#" && $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f_src, f_suc, f_hit, f_dirty, f_vd, f_vi, f_way, f_flags) == 8) begin
                    txn_no++;
                    run_txn(l2_pkg::req_src_e'(f_src[1:0]), f_suc[0], f_hit[7:0], f_dirty[0],
                            f_vd[2:0], f_vi[1:0], f_way[2:0], f_flags[2:0]);
                end
            end
            $fclose(fd);
        end
        if (txn_no == 0) begin
            fail_cnt++;
            $display("no transactions were read from the vector file");
        end
        assert_cnt = UUT.u_props.assert_fails;
        $display("transactions %0d, check errors %0d, other errors %0d, assertion failures %0d",
                 txn_no, err_cnt, fail_cnt, assert_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && assert_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/l2_ctrl_vectors.txt */
# src suc hit dirty victim_d victim_i exp_way flags (hex, src 1 iread 2 dread 3 dwrite)
# flags bit0 flush raised, bit1 memory write expected, bit2 memory read expected
1 0 01 0 0 0 0 0
1 0 24 0 5 1 2 0
2 0 80 0 0 0 7 0
2 0 6c 0 1 0 2 0
3 0 10 0 0 0 4 0
3 0 c2 0 6 0 1 0
2 0 00 0 5 0 5 4
1 0 00 0 6 3 3 4
1 0 00 0 7 1 1 4
2 0 00 1 3 0 3 6
3 0 00 0 6 0 6 4
3 0 00 1 2 0 2 6
1 0 00 1 4 2 2 6
3 1 00 0 0 0 0 2
3 1 ff 0 0 0 0 2
2 1 00 0 0 0 0 4
2 1 08 0 0 0 0 4
1 0 01 0 0 0 0 1
1 0 00 0 0 2 0 1
2 0 01 0 0 0 0 1

/* all.f */
+incdir+rtl
rtl/l2_pkg.sv
rtl/l2_way_tracker.sv
rtl/l2_state_seq.sv
rtl/l2_cmd_decode.sv
rtl/l2_ctrl_top.sv
tests/l2_ctrl_props.sv
tests/l2_ctrl_tb.sv
